/* cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Address and word sizes
`define CACHE_ADDR_BITS     32
`define CACHE_DATA_BITS     32

// Cache geometry
`define CACHE_WAYS          2
`define CACHE_SETS          4
`define CACHE_BLOCK_BYTES   8

// Derived address fields
`define CACHE_OFFSET_BITS   $clog2(`CACHE_BLOCK_BYTES)
`define CACHE_SET_BITS      $clog2(`CACHE_SETS)
`define CACHE_TAG_BITS      (`CACHE_ADDR_BITS - `CACHE_SET_BITS - `CACHE_OFFSET_BITS)

// Derived way index, block and word select widths
`define CACHE_WAY_BITS      $clog2(`CACHE_WAYS)
`define CACHE_BLOCK_BITS    (`CACHE_BLOCK_BYTES * 8)
`define CACHE_WSEL_BITS     $clog2(`CACHE_BLOCK_BITS / `CACHE_DATA_BITS)

`endif

/* cache_ctrl.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_ctrl (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,

    input  logic                                  req_valid_i,
    input  cache_pkg::core_req_t                  req_i,
    output logic                                  req_ready_o,
    output logic                                  rsp_valid_o,
    output cache_pkg::core_rsp_t                  rsp_o,
    input  logic                                  rsp_ready_i,

    output logic                                  mem_req_valid_o,
    output cache_pkg::mem_req_t                   mem_req_o,
    input  logic                                  mem_req_ready_i,
    input  logic                                  mem_rsp_valid_i,
    input  cache_pkg::block_t                     mem_rsp_data_i,
    output logic                                  mem_rsp_ready_o,

    output cache_pkg::set_t                       rd_set_o,
    output logic                                  upd_en_o,
    output cache_pkg::set_t                       upd_set_o,
    output cache_pkg::way_t                       upd_way_o,
    output cache_pkg::tag_t                       upd_tag_o,
    output cache_pkg::block_t                     upd_block_o,
    output logic                                  upd_valid_o,
    output logic                                  upd_dirty_o,

    input  cache_pkg::tag_t   [`CACHE_WAYS-1:0]   set_tags_i,
    input  cache_pkg::block_t [`CACHE_WAYS-1:0]   set_blocks_i,
    input  logic              [`CACHE_WAYS-1:0]   set_dirty_i,
    input  logic                                  hit_i,
    input  cache_pkg::way_t                       hit_way_i,
    input  logic                                  free_i,
    input  cache_pkg::way_t                       free_way_i,
    input  cache_pkg::way_t                       victim_way_i
);
    import cache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    // Store output holds the request's set from the second lookup cycle on
    logic        rd_done_q;
    core_req_t   req_q;
    way_t        way_q;
    core_rsp_t   rsp_q;
    mem_req_t    mem_req_q;
    mem_req_t    wb_req;
    mem_req_t    refill_req;
    block_t      merged_block;
    way_t        alloc_way;
    logic        evict_dirty;
    logic        decide;

    assign decide      = (state_q == ST_LOOKUP) && rd_done_q;
    assign alloc_way   = free_i ? free_way_i : victim_way_i;
    assign evict_dirty = !free_i && set_dirty_i[victim_way_i];

    always_comb begin
        merged_block = set_blocks_i[hit_way_i];
        merged_block[addr_word(req_q.addr) * `CACHE_DATA_BITS +: `CACHE_DATA_BITS] = req_q.wdata;
    end

    always_comb begin
        wb_req.addr      = block_addr(set_tags_i[victim_way_i], addr_set(req_q.addr));
        wb_req.write     = 1'b1;
        wb_req.wdata     = set_blocks_i[victim_way_i];
        refill_req.addr  = block_addr(addr_tag(req_q.addr), addr_set(req_q.addr));
        refill_req.write = 1'b0;
        refill_req.wdata = '0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:        if (req_valid_i) state_d = ST_LOOKUP;
            ST_LOOKUP: begin
                if (rd_done_q) begin
                    if (hit_i) begin
                        state_d = req_q.write ? ST_IDLE : ST_RESPOND;
                    end else begin
                        state_d = evict_dirty ? ST_WB_REQ : ST_REFILL_REQ;
                    end
                end
            end
            ST_RESPOND:     if (rsp_ready_i) state_d = ST_IDLE;
            ST_WB_REQ:      if (mem_req_ready_i) state_d = ST_REFILL_REQ;
            ST_REFILL_REQ:  if (mem_req_ready_i) state_d = ST_REFILL_WAIT;
            ST_REFILL_WAIT: if (mem_rsp_valid_i) state_d = ST_LOOKUP;
            default:        state_d = ST_IDLE;
        endcase
    end

    // Write hit merges the word, refill installs a clean block
    always_comb begin
        upd_en_o    = 1'b0;
        upd_way_o   = hit_way_i;
        upd_block_o = merged_block;
        upd_dirty_o = 1'b1;
        if (decide && hit_i && req_q.write) begin
            upd_en_o = 1'b1;
        end else if (state_q == ST_REFILL_WAIT && mem_rsp_valid_i) begin
            upd_en_o    = 1'b1;
            upd_way_o   = way_q;
            upd_block_o = mem_rsp_data_i;
            upd_dirty_o = 1'b0;
        end
    end

    assign upd_set_o   = addr_set(req_q.addr);
    assign upd_tag_o   = addr_tag(req_q.addr);
    assign upd_valid_o = 1'b1;
    assign rd_set_o    = addr_set(req_q.addr);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= ST_IDLE;
            rd_done_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_done_q <= (state_q == ST_LOOKUP) && (state_d == ST_LOOKUP);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (decide && hit_i && !req_q.write) begin
            rsp_q.rdata <= set_blocks_i[hit_way_i][addr_word(req_q.addr) * `CACHE_DATA_BITS
                                                   +: `CACHE_DATA_BITS];
        end
        if (decide && !hit_i) begin
            way_q     <= alloc_way;
            mem_req_q <= evict_dirty ? wb_req : refill_req;
        end
        // Write-back accepted, the refill read follows
        if (state_q == ST_WB_REQ && mem_req_ready_i) begin
            mem_req_q <= refill_req;
        end
    end

    assign req_ready_o     = (state_q == ST_IDLE);
    assign rsp_valid_o     = (state_q == ST_RESPOND);
    assign rsp_o           = rsp_q;
    assign mem_req_valid_o = (state_q == ST_WB_REQ) || (state_q == ST_REFILL_REQ);
    assign mem_req_o       = mem_req_q;
    assign mem_rsp_ready_o = (state_q == ST_REFILL_WAIT);

endmodule

/* cache_lookup.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_lookup (
    input  logic                                clk_i,
    input  logic                                rstn_i,

    input  cache_pkg::tag_t                     req_tag_i,
    input  cache_pkg::tag_t [`CACHE_WAYS-1:0]   set_tags_i,
    input  logic            [`CACHE_WAYS-1:0]   set_valid_i,

    output logic                                hit_o,
    output cache_pkg::way_t                     hit_way_o,
    output logic                                free_o,
    output cache_pkg::way_t                     free_way_o,
    output cache_pkg::way_t                     victim_way_o
);
    import cache_pkg::*;

    way_t rr_q;

    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (set_valid_i[w] && set_tags_i[w] == req_tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = way_t'(w);
            end
        end
    end

    // Walk downwards so the lowest invalid way wins
    always_comb begin
        free_o     = 1'b0;
        free_way_o = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!set_valid_i[w]) begin
                free_o     = 1'b1;
                free_way_o = way_t'(w);
            end
        end
    end

    // Round-robin victim, free running
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
        end else if (rr_q == way_t'(`CACHE_WAYS - 1)) begin
            rr_q <= '0;
        end else begin
            rr_q <= rr_q + 1'b1;
        end
    end

    assign victim_way_o = rr_q;

endmodule

/* cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_BITS-1:0]  addr_t;
    typedef logic [`CACHE_DATA_BITS-1:0]  word_t;
    typedef logic [`CACHE_TAG_BITS-1:0]   tag_t;
    typedef logic [`CACHE_SET_BITS-1:0]   set_t;
    typedef logic [`CACHE_WAY_BITS-1:0]   way_t;
    typedef logic [`CACHE_WSEL_BITS-1:0]  wsel_t;
    typedef logic [`CACHE_BLOCK_BITS-1:0] block_t;

    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        word_t rdata;
    } core_rsp_t;

    // Block-aligned memory request, wdata only matters for write-back
    typedef struct packed {
        addr_t  addr;
        logic   write;
        block_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_RESPOND,
        ST_WB_REQ,
        ST_REFILL_REQ,
        ST_REFILL_WAIT
    } ctrl_state_t;

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    endfunction

    function automatic set_t addr_set(input addr_t addr);
        return addr[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];
    endfunction

    function automatic wsel_t addr_word(input addr_t addr);
        return addr[`CACHE_OFFSET_BITS-1 -: `CACHE_WSEL_BITS];
    endfunction

    function automatic addr_t block_addr(input tag_t tag, input set_t set);
        return {tag, set, {`CACHE_OFFSET_BITS{1'b0}}};
    endfunction

endpackage

/* cache_store.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_store (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,

    input  cache_pkg::set_t                       rd_set_i,

    input  logic                                  upd_en_i,
    input  cache_pkg::set_t                       upd_set_i,
    input  cache_pkg::way_t                       upd_way_i,
    input  cache_pkg::tag_t                       upd_tag_i,
    input  cache_pkg::block_t                     upd_block_i,
    input  logic                                  upd_valid_i,
    input  logic                                  upd_dirty_i,

    output cache_pkg::tag_t   [`CACHE_WAYS-1:0]   set_tags_o,
    output cache_pkg::block_t [`CACHE_WAYS-1:0]   set_blocks_o,
    output logic              [`CACHE_WAYS-1:0]   set_valid_o,
    output logic              [`CACHE_WAYS-1:0]   set_dirty_o
);
    import cache_pkg::*;

    tag_t                   tag_mem   [`CACHE_SETS][`CACHE_WAYS];
    block_t                 block_mem [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_q   [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q   [`CACHE_SETS];

    // Tag and block arrays, read out one set per cycle
    always_ff @(posedge clk_i) begin
        if (upd_en_i) begin
            tag_mem[upd_set_i][upd_way_i]   <= upd_tag_i;
            block_mem[upd_set_i][upd_way_i] <= upd_block_i;
        end
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            set_tags_o[w]   <= tag_mem[rd_set_i][w];
            set_blocks_o[w] <= block_mem[rd_set_i][w];
        end
    end

    // Status bits
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            set_valid_o <= '0;
            set_dirty_o <= '0;
        end else begin
            if (upd_en_i) begin
                valid_q[upd_set_i][upd_way_i] <= upd_valid_i;
                dirty_q[upd_set_i][upd_way_i] <= upd_dirty_i;
            end
            set_valid_o <= valid_q[rd_set_i];
            set_dirty_o <= dirty_q[rd_set_i];
        end
    end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  req_valid_i,
    input  cache_pkg::core_req_t  req_i,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,
    output cache_pkg::core_rsp_t  rsp_o,
    input  logic                  rsp_ready_i,

    output logic                  mem_req_valid_o,
    output cache_pkg::mem_req_t   mem_req_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_rsp_valid_i,
    input  cache_pkg::block_t     mem_rsp_data_i,
    output logic                  mem_rsp_ready_o
);
    import cache_pkg::*;

    set_t                     rd_set;
    logic                     upd_en;
    set_t                     upd_set;
    way_t                     upd_way;
    // Always the tag of the request in flight
    tag_t                     req_tag;
    block_t                   upd_block;
    logic                     upd_valid;
    logic                     upd_dirty;
    tag_t   [`CACHE_WAYS-1:0] set_tags;
    block_t [`CACHE_WAYS-1:0] set_blocks;
    logic   [`CACHE_WAYS-1:0] set_valid;
    logic   [`CACHE_WAYS-1:0] set_dirty;
    logic                     hit;
    way_t                     hit_way;
    logic                     free;
    way_t                     free_way;
    way_t                     victim_way;

    cache_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .rd_set_o        (rd_set),
        .upd_en_o        (upd_en),
        .upd_set_o       (upd_set),
        .upd_way_o       (upd_way),
        .upd_tag_o       (req_tag),
        .upd_block_o     (upd_block),
        .upd_valid_o     (upd_valid),
        .upd_dirty_o     (upd_dirty),
        .set_tags_i      (set_tags),
        .set_blocks_i    (set_blocks),
        .set_dirty_i     (set_dirty),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .free_i          (free),
        .free_way_i      (free_way),
        .victim_way_i    (victim_way)
    );

    cache_store u_store (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rd_set_i     (rd_set),
        .upd_en_i     (upd_en),
        .upd_set_i    (upd_set),
        .upd_way_i    (upd_way),
        .upd_tag_i    (req_tag),
        .upd_block_i  (upd_block),
        .upd_valid_i  (upd_valid),
        .upd_dirty_i  (upd_dirty),
        .set_tags_o   (set_tags),
        .set_blocks_o (set_blocks),
        .set_valid_o  (set_valid),
        .set_dirty_o  (set_dirty)
    );

    cache_lookup u_lookup (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_tag_i    (req_tag),
        .set_tags_i   (set_tags),
        .set_valid_i  (set_valid),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .free_o       (free),
        .free_way_o   (free_way),
        .victim_way_o (victim_way)
    );

endmodule

/* list.f */
+incdir+.
cache_pkg.sv
cache_store.sv
cache_lookup.sv
cache_ctrl.sv
cache_top.sv
tb_main_mem.sv
tb_cache.sv

/* run.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_cache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

/* tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;

    localparam int SEED    = 32'h4274;
    localparam int TIMEOUT = 200;

    typedef enum logic [2:0] {
        OP_RD,
        OP_RD_COLD,
        OP_RD_HIT,
        OP_RD_REF,
        OP_WR,
        OP_RESET
    } op_t;

    typedef struct packed {
        op_t   op;
        addr_t addr;
        word_t wdata;
        word_t expected;
        logic  stall;
    } step_t;

    logic      clk;
    logic      rstn;
    logic      req_valid;
    core_req_t req;
    logic      req_ready;
    logic      rsp_valid;
    core_rsp_t rsp;
    logic      rsp_ready;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    block_t    mem_rsp_data;
    logic      mem_rsp_ready;

    step_t     steps [$];
    string     names [$];
    // Core view of memory and the memory content confirmed by write-backs
    block_t    model_blk [addr_t];
    block_t    mem_view  [addr_t];
    int        wb_checked;
    integer    seed;

    cache_top DUT (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .req_ready_o     (req_ready),
        .rsp_valid_o     (rsp_valid),
        .rsp_o           (rsp),
        .rsp_ready_i     (rsp_ready),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_req_ready_i (mem_req_ready),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_data_i  (mem_rsp_data),
        .mem_rsp_ready_o (mem_rsp_ready)
    );

    tb_main_mem #(.SEED(SEED)) u_mem (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_valid_i (mem_req_valid),
        .req_i       (mem_req),
        .req_ready_o (mem_req_ready),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_data_o  (mem_rsp_data),
        .rsp_ready_i (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic addr_t block_base(input addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic block_t fill_block(input addr_t base);
        return {base + 32'd4, base} ^ {2{32'hA5A5_0000}};
    endfunction

    function automatic block_t predict_block(input addr_t a);
        return model_blk.exists(block_base(a)) ? model_blk[block_base(a)]
                                               : fill_block(block_base(a));
    endfunction

    function automatic word_t predict_word(input addr_t a);
        block_t b;
        b = predict_block(a);
        return a[2] ? b[63:32] : b[31:0];
    endfunction

    task automatic update_model(input addr_t a, input word_t w);
        block_t b;
        b = predict_block(a);
        if (a[2]) b[63:32] = w;
        else b[31:0] = w;
        model_blk[block_base(a)] = b;
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Result: FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rstn = 1'b0;
        repeat (8) next_cycle();
        rstn = 1'b1;
        check("reset req_ready_o", 1, req_ready);
        check("reset rsp_valid_o", 0, rsp_valid);
        check("reset mem_req_valid_o", 0, mem_req_valid);
        check("reset mem_rsp_ready_o", 0, mem_rsp_ready);
    endtask

    task automatic send_request(input step_t s, input string name);
        int   n;
        logic accepted;
        n          = 0;
        accepted   = 1'b0;
        req_valid  = 1'b1;
        req.addr   = s.addr;
        req.write  = (s.op == OP_WR);
        req.wdata  = s.wdata;
        while (!accepted) begin
            if (n == TIMEOUT) report_timeout({"request acceptance in ", name});
            accepted = req_ready;
            next_cycle();
            n++;
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (!req_ready) begin
            if (n == TIMEOUT) report_timeout({"write completion in ", name});
            next_cycle();
            n++;
        end
    endtask

    task automatic take_response(input string name, input logic stall, output word_t data);
        int    n;
        logic  taken;
        word_t held;
        n = 0;
        while (!rsp_valid) begin
            if (n == TIMEOUT) report_timeout({"read response in ", name});
            next_cycle();
            n++;
        end
        held  = rsp.rdata;
        taken = 1'b0;
        n     = 0;
        // Response must hold and block new requests until taken
        while (!taken) begin
            if (n == TIMEOUT) report_timeout({"response handshake in ", name});
            rsp_ready = stall ? (($random(seed) & 3) == 0) : 1'b1;
            check({name, " rsp_valid_o held"}, 1, rsp_valid);
            check({name, " rsp_o stable"}, held, rsp.rdata);
            check({name, " req_ready_o low"}, 0, req_ready);
            taken = rsp_ready;
            next_cycle();
            n++;
        end
        rsp_ready = 1'b0;
        data      = held;
    endtask

    task automatic check_writebacks();
        addr_t a;
        while (wb_checked < u_mem.wb_count) begin
            a = u_mem.wb_addr_log[wb_checked];
            check("writeback alignment", 0, a[2:0]);
            check("writeback block", predict_block(a), u_mem.wb_block_log[wb_checked]);
            mem_view[a] = u_mem.wb_block_log[wb_checked];
            wb_checked++;
        end
    endtask

    task automatic run_step(input step_t s, input string name);
        word_t got;
        int    rd_before;
        if (s.op == OP_RESET) begin
            apply_reset();
            // Dirty blocks are lost and only written-back data survives
            model_blk.delete();
            foreach (mem_view[k]) model_blk[k] = mem_view[k];
        end else begin
            rd_before = u_mem.rd_count;
            send_request(s, name);
            if (s.op == OP_WR) begin
                update_model(s.addr, s.wdata);
                wait_ready(name);
            end else begin
                take_response(name, s.stall, got);
                if (s.op == OP_RD_REF) check(name, predict_word(s.addr), got);
                else check(name, s.expected, got);
                if (s.op == OP_RD_COLD || s.op == OP_RD_REF) begin
                    check({name, " memory read count"}, rd_before + 1, u_mem.rd_count);
                    check({name, " memory read address"}, block_base(s.addr),
                          u_mem.last_rd_addr);
                end
                if (s.op == OP_RD_HIT) begin
                    check({name, " no memory read"}, rd_before, u_mem.rd_count);
                end
            end
            check_writebacks();
        end
    endtask

    task automatic add_step(input op_t op, input addr_t addr, input word_t wdata,
                            input word_t expected, input logic stall, input string name);
        step_t s;
        s = '{op, addr, wdata, expected, stall};
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic load_steps();
        add_step(OP_RD_COLD, 32'h0000_0104, 32'h0,         32'hA5A5_0104, 1'b0, "cold_read_miss");
        add_step(OP_RD_HIT,  32'h0000_0100, 32'h0,         32'hA5A5_0100, 1'b0, "cold_read_lower");
        add_step(OP_WR,      32'h0000_0100, 32'h1234_5678, 32'h0,         1'b0, "write_hit");
        add_step(OP_RD,      32'h0000_0100, 32'h0,         32'h1234_5678, 1'b0, "read_after_write");
        add_step(OP_RD,      32'h0000_0104, 32'h0,         32'hA5A5_0104, 1'b0, "read_other_word");
        add_step(OP_WR,      32'h0000_0208, 32'hCAFE_0001, 32'h0,         1'b0, "write_miss");
        add_step(OP_RD_HIT,  32'h0000_0208, 32'h0,         32'hCAFE_0001, 1'b0, "read_write_miss");
        add_step(OP_RD,      32'h0000_020C, 32'h0,         32'hA5A5_020C, 1'b0, "read_miss_other");
        // Three tags in set 2 force a dirty eviction
        add_step(OP_WR,      32'h0000_1010, 32'hAAAA_0001, 32'h0,         1'b0, "evict_write_a");
        add_step(OP_WR,      32'h0000_2010, 32'hBBBB_0002, 32'h0,         1'b0, "evict_write_b");
        add_step(OP_WR,      32'h0000_3014, 32'hCCCC_0003, 32'h0,         1'b0, "evict_write_c");
        add_step(OP_RD,      32'h0000_1010, 32'h0,         32'hAAAA_0001, 1'b0, "evict_read_a");
        add_step(OP_RD,      32'h0000_2010, 32'h0,         32'hBBBB_0002, 1'b0, "evict_read_b");
        add_step(OP_RD,      32'h0000_3014, 32'h0,         32'hCCCC_0003, 1'b0, "evict_read_c");
        add_step(OP_RD,      32'h0000_3010, 32'h0,         32'hA5A5_3010, 1'b0, "evict_read_c_low");
        add_step(OP_RD,      32'h0000_0100, 32'h0,         32'h1234_5678, 1'b1, "stall_read_hit");
        add_step(OP_RD,      32'h0000_0500, 32'h0,         32'hA5A5_0500, 1'b1, "stall_read_miss");
        add_step(OP_RD,      32'h0000_0904, 32'h0,         32'hA5A5_0904, 1'b1, "stall_read_evict");
        add_step(OP_RD,      32'h0000_020C, 32'h0,         32'hA5A5_020C, 1'b1, "stall_read_set1");
        add_step(OP_RESET,   32'h0,         32'h0,         32'h0,         1'b0, "reset_mid_test");
        add_step(OP_RD_REF,  32'h0000_0100, 32'h0,         32'h0,         1'b0, "reset_read_0100");
        add_step(OP_RD_REF,  32'h0000_1010, 32'h0,         32'h0,         1'b0, "reset_read_1010");
        add_step(OP_RD_REF,  32'h0000_2010, 32'h0,         32'h0,         1'b0, "reset_read_2010");
        add_step(OP_RD_REF,  32'h0000_3014, 32'h0,         32'h0,         1'b0, "reset_read_3014");
        add_step(OP_RD_REF,  32'h0000_0208, 32'h0,         32'h0,         1'b0, "reset_read_0208");
    endtask

    initial begin
        seed       = SEED;
        wb_checked = 0;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        load_steps();
        apply_reset();
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i], names[i]);
        end
        check("writeback seen", 1, u_mem.wb_count > 0);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb_main_mem.sv */
`timescale 1ns/1ps

module tb_main_mem #(
    parameter int SEED = 32'h4274
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  logic                 req_valid_i,
    input  cache_pkg::mem_req_t  req_i,
    output logic                 req_ready_o,

    output logic                 rsp_valid_o,
    output cache_pkg::block_t    rsp_data_o,
    input  logic                 rsp_ready_i
);
    import cache_pkg::*;

    // Write-back log and last read, inspected by the testbench
    addr_t    wb_addr_log  [64];
    block_t   wb_block_log [64];
    int       wb_count;
    addr_t    last_rd_addr;
    int       rd_count;

    block_t   mem [addr_t];
    integer   seed;
    mem_req_t req;
    int       wait_cnt;
    logic     taken;

    // Untouched words read as their own address XOR a constant
    function automatic block_t fill_block(input addr_t base);
        return {base + 32'd4, base} ^ {2{32'hA5A5_0000}};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    initial begin
        seed         = SEED;
        wb_count     = 0;
        rd_count     = 0;
        last_rd_addr = '0;
        req_ready_o  = 1'b0;
        rsp_valid_o  = 1'b0;
        rsp_data_o   = '0;
        forever begin
            @(posedge clk_i);
            #2;
            if (rstn_i && req_valid_i) begin
                req = req_i;
                wait_cycles({$random(seed)} % 4);
                req_ready_o = 1'b1;
                wait_cycles(1);
                req_ready_o = 1'b0;
                if (req.write) begin
                    mem[req.addr] = req.wdata;
                    if (wb_count < 64) begin
                        wb_addr_log[wb_count]  = req.addr;
                        wb_block_log[wb_count] = req.wdata;
                    end
                    wb_count++;
                end else begin
                    last_rd_addr = req.addr;
                    rd_count++;
                    wait_cycles({$random(seed)} % 5);
                    rsp_valid_o = 1'b1;
                    rsp_data_o  = mem.exists(req.addr) ? mem[req.addr] : fill_block(req.addr);
                    wait_cnt    = 0;
                    taken       = 1'b0;
                    while (!taken && wait_cnt < 100) begin
                        taken = rsp_ready_i;
                        wait_cycles(1);
                        wait_cnt++;
                    end
                    rsp_valid_o = 1'b0;
                    if (!taken) begin
                        $display("memory: refill data was never taken by the cache");
                    end
                end
            end
        end
    end

endmodule
